/* verilog.f */
common/opm_pkg.sv
logic/bus_sync.sv
loreg/loreg_file.sv
hireg/hireg_latch.sv
hireg/chan_sr.sv
logic/busy_status.sv
logic/opm_reg_top.sv
test/tb_clkgen.sv
test/opm_reg_asserts.sv
test/tb_opm_reg.sv

/* run.sh */
#!/bin/sh
# build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_opm_reg -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_opm_reg > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* test/tb_opm_reg.sv */
`timescale 1ns/1ps

module tb_opm_reg import opm_pkg::*; ();

localparam int DRIVE_DLY    = 2;        // ns after the rising edge
localparam int RESET_CYCLES = 8;
localparam int MAX_CYCLES   = 20000;
localparam int WR_LOW       = 4;        // write pulse width in cycles
localparam int STROBE_LIMIT = 10;
localparam int BUSY_LIMIT   = 50;

logic              clk;
logic              mrst_n;
logic              cs_n;
logic              rd_n;
logic              wr_n;
logic              a0;
logic [7:0]        d_in;
logic              timera_flag;
logic              timerb_flag;
logic [7:0]        d_out;
logic              d_oe;
timer_cfg_t        timer;
lfo_cfg_t          lfo;
noise_cfg_t        noise;
logic              timera_frst;
logic              timerb_frst;
logic              lfrq_update;
logic [SLOT_W-1:0] ch_slot;
ch_params_t        ch_params;

// expected state
timer_cfg_t exp_timer;
lfo_cfg_t   exp_lfo;
noise_cfg_t exp_noise;
ch_params_t exp_ch [NUM_CH];
logic [2:0] strobe_at_ld;   // lfrq, frst b, frst a seen with data_ld
int         cycle_cnt;
int         frsta_cnt;
int         frstb_cnt;
int         lfrq_cnt;

tb_clkgen u_clkgen (
    .o_clk (clk)
);

opm_reg_top i_dut (
    .i_EMUCLK      (clk),
    .mrst_n        (mrst_n),
    .i_cs_n        (cs_n),
    .i_rd_n        (rd_n),
    .i_wr_n        (wr_n),
    .i_a0          (a0),
    .i_d           (d_in),
    .i_timera_flag (timera_flag),
    .i_timerb_flag (timerb_flag),
    .o_d           (d_out),
    .o_d_oe        (d_oe),
    .o_timer       (timer),
    .o_lfo         (lfo),
    .o_noise       (noise),
    .o_timera_frst (timera_frst),
    .o_timerb_frst (timerb_frst),
    .o_lfrq_update (lfrq_update),
    .o_ch_slot     (ch_slot),
    .o_ch_params   (ch_params)
);

bind opm_reg_top opm_reg_asserts u_asserts (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_bus_wr      (bus_wr),
    .i_d_oe        (o_d_oe),
    .i_grp_we      (grp_we),
    .i_timera_frst (o_timera_frst),
    .i_timerb_frst (o_timerb_frst),
    .i_lfrq_update (o_lfrq_update)
);

// pulse counters and run limit, sampled mid cycle
always @(negedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timera_frst) frsta_cnt <= frsta_cnt + 1;
    if (timerb_frst) frstb_cnt <= frstb_cnt + 1;
    if (lfrq_update) lfrq_cnt <= lfrq_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
        $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "cycle limit reached");
    end
end

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic stop_on_error();
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
endtask

task automatic check_timer(input string name, input timer_cfg_t exp, input timer_cfg_t act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_lfo(input string name, input lfo_cfg_t exp, input lfo_cfg_t act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_noise(input string name, input noise_cfg_t exp, input noise_cfg_t act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_ch(input string name, input ch_params_t exp, input ch_params_t act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_slot(input string name, input logic [SLOT_W-1:0] exp,
                          input logic [SLOT_W-1:0] act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
        stop_on_error();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("ERROR at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
        stop_on_error();
    end
endtask

////////////////////////////////////////////////////////////
// bus access
////////////////////////////////////////////////////////////

task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
endtask

function automatic logic [7:0] rand_byte();
    return 8'($urandom);
endfunction

// a0 and d stay on the pins until the next write
task automatic pin_write(input logic a0_val, input logic [7:0] data);
    a0   = a0_val;
    d_in = data;
    cs_n = 1'b0;
    wr_n = 1'b0;
    repeat (WR_LOW) next_cycle();
    wr_n = 1'b1;
    cs_n = 1'b1;
endtask

task automatic wait_strobe(input logic is_data);
    int n;
    n = 0;
    while ((is_data ? i_dut.bus_wr.data_ld : i_dut.bus_wr.addr_ld) !== 1'b1) begin
        if (n == STROBE_LIMIT) begin
            $display("no write strobe within %0d cycles at %0t ns", STROBE_LIMIT, $time);
            stop_on_error();
        end
        next_cycle();
        n++;
    end
    if (is_data) begin
        strobe_at_ld = {lfrq_update, timerb_frst, timera_frst};
    end
endtask

task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    while (d_out[7] !== level) begin
        if (n == limit) begin
            $display("busy did not go to %0b within %0d cycles at %0t ns", level, limit, $time);
            stop_on_error();
        end
        next_cycle();
        n++;
    end
endtask

task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
    pin_write(1'b0, addr);
    wait_strobe(1'b0);
    wait_busy(1'b0, BUSY_LIMIT);
    pin_write(1'b1, data);
    wait_strobe(1'b1);
    wait_busy(1'b1, STROBE_LIMIT);  // busy follows the data byte
    wait_busy(1'b0, BUSY_LIMIT);
endtask

// watch every slot go by twice
task automatic check_ring(input int cycles);
    logic [SLOT_W-1:0] exp_slot;
    exp_slot = ch_slot + 1'b1;  // shown channel steps by one each cycle
    repeat (cycles) begin
        next_cycle();
        check_slot("o_ch_slot", exp_slot, ch_slot);
        check_ch($sformatf("o_ch_params slot %0d", ch_slot), exp_ch[ch_slot], ch_params);
        exp_slot = exp_slot + 1'b1;
    end
endtask

////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////

task automatic test_reset();
    cs_n = 1'b0;    // status read held during reset
    rd_n = 1'b0;
    a0   = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    check_bit("o_d_oe", 1'b0, d_oe);
    mrst_n = 1'b1;
    next_cycle();
    exp_timer = '0;
    exp_lfo   = '0;
    exp_noise = '0;
    for (int i = 0; i < NUM_CH; i++) begin
        exp_ch[i] = '0;
    end
    check_timer("o_timer", exp_timer, timer);
    check_lfo("o_lfo", exp_lfo, lfo);
    check_noise("o_noise", exp_noise, noise);
    timera_flag = 1'($urandom);
    timerb_flag = 1'($urandom);
    #1;
    check_bit("o_d_oe", 1'b1, d_oe);
    check_byte("o_d", {1'b0, 5'b00000, timerb_flag, timera_flag}, d_out);
    cs_n = 1'b1;
    rd_n = 1'b1;
    check_ring(2 * NUM_CH);
endtask

task automatic test_lo_regs();
    logic [7:0] v;
    v = rand_byte();
    reg_write(ADDR_NOISE, v);
    exp_noise.ne   = v[7];
    exp_noise.nfrq = v[4:0];
    v = rand_byte();
    reg_write(ADDR_CLKA1, v);
    exp_timer.clka[9:2] = v;
    v = rand_byte();
    reg_write(ADDR_CLKA2, v);
    exp_timer.clka[1:0] = v[1:0];
    v = rand_byte();
    reg_write(ADDR_CLKB, v);
    exp_timer.clkb = v;
    v = rand_byte();
    reg_write(ADDR_LFRQ, v);
    exp_lfo.lfrq = v;
    v = rand_byte();
    reg_write(ADDR_WAVE, v);
    exp_lfo.w = v[1:0];
    check_timer("o_timer", exp_timer, timer);
    check_lfo("o_lfo", exp_lfo, lfo);
    check_noise("o_noise", exp_noise, noise);
    v = rand_byte() | 8'h80;    // pmd
    reg_write(ADDR_PMD_AMD, v);
    exp_lfo.pmd = v[6:0];
    check_lfo("o_lfo after pmd write", exp_lfo, lfo);
    v = rand_byte() & 8'h7F;    // amd
    reg_write(ADDR_PMD_AMD, v);
    exp_lfo.amd = v[6:0];
    check_lfo("o_lfo after amd write", exp_lfo, lfo);
endtask

task automatic test_strobes();
    int         a_base;
    int         b_base;
    int         l_base;
    logic [7:0] v;
    // run and irq bits set without any flag reset
    a_base = frsta_cnt;
    b_base = frstb_cnt;
    reg_write(ADDR_TIMER_CTRL, 8'h0F);
    exp_timer.run_a    = 1'b1;
    exp_timer.run_b    = 1'b1;
    exp_timer.irq_en_a = 1'b1;
    exp_timer.irq_en_b = 1'b1;
    check_timer("o_timer", exp_timer, timer);
    check_count("o_timera_frst pulses", 0, frsta_cnt - a_base);
    check_count("o_timerb_frst pulses", 0, frstb_cnt - b_base);
    a_base = frsta_cnt;
    b_base = frstb_cnt;
    reg_write(ADDR_TIMER_CTRL, 8'h30);
    check_bit("o_timera_frst", 1'b1, strobe_at_ld[0]);
    check_bit("o_timerb_frst", 1'b1, strobe_at_ld[1]);
    check_count("o_timera_frst pulses", 1, frsta_cnt - a_base);
    check_count("o_timerb_frst pulses", 1, frstb_cnt - b_base);
    exp_timer.run_a    = 1'b0;
    exp_timer.run_b    = 1'b0;
    exp_timer.irq_en_a = 1'b0;
    exp_timer.irq_en_b = 1'b0;
    check_timer("o_timer", exp_timer, timer);
    l_base = lfrq_cnt;
    v = rand_byte();
    reg_write(ADDR_LFRQ, v);
    exp_lfo.lfrq = v;
    check_bit("o_lfrq_update", 1'b1, strobe_at_ld[2]);
    check_count("o_lfrq_update pulses", 1, lfrq_cnt - l_base);
    check_lfo("o_lfo", exp_lfo, lfo);
endtask

task automatic test_channels();
    logic [SLOT_W-1:0] ch;
    logic [7:0]        v;
    repeat (3) begin
        ch = SLOT_W'($urandom % NUM_CH);
        for (int g = 0; g < NUM_GRP; g++) begin
            v = rand_byte();
            reg_write({3'b001, 2'(g), ch}, v);
            case (g)
                0: begin
                    exp_ch[ch].rl  = v[7:6];
                    exp_ch[ch].fl  = v[5:3];
                    exp_ch[ch].alg = v[2:0];
                end
                1: exp_ch[ch].kc = v[6:0];
                2: exp_ch[ch].kf = v[7:2];
                default: begin
                    exp_ch[ch].pms = v[6:4];
                    exp_ch[ch].ams = v[1:0];
                end
            endcase
        end
    end
    check_ring(2 * NUM_CH);
endtask

task automatic test_busy_and_oe();
    logic [7:0] v;
    logic [2:0] pins;
    v = rand_byte();
    reg_write(ADDR_CLKB, v);    // busy rise and fall checked on the way
    exp_timer.clkb = v;
    check_timer("o_timer", exp_timer, timer);
    for (int k = 0; k < 8; k++) begin
        pins        = 3'(k);
        cs_n        = pins[2];
        rd_n        = pins[1];
        a0          = pins[0];
        timera_flag = 1'($urandom);
        timerb_flag = 1'($urandom);
        #1;
        check_bit("o_d_oe", ~pins[2] & ~pins[1] & pins[0], d_oe);
        check_byte("o_d", {1'b0, 5'b00000, timerb_flag, timera_flag}, d_out);
        next_cycle();
    end
    cs_n = 1'b1;
    rd_n = 1'b1;
endtask

initial begin
    void'($urandom(32'h3643_6efd));
    mrst_n       = 1'b0;
    cs_n         = 1'b1;
    rd_n         = 1'b1;
    wr_n         = 1'b1;
    a0           = 1'b0;
    d_in         = 8'h00;
    timera_flag  = 1'b0;
    timerb_flag  = 1'b0;
    strobe_at_ld = 3'b000;
    test_reset();
    test_lo_regs();
    test_strobes();
    test_channels();
    test_busy_and_oe();
    $display("STATUS: PASS");
    $finish;
end

endmodule

/* test/opm_reg_asserts.sv */
`timescale 1ns/1ps

module opm_reg_asserts import opm_pkg::*; (
    input logic               i_EMUCLK,
    input logic               mrst_n,
    input bus_wr_t            i_bus_wr,
    input logic               i_d_oe,
    input logic [NUM_GRP-1:0] i_grp_we,
    input logic               i_timera_frst,
    input logic               i_timerb_frst,
    input logic               i_lfrq_update
);

////////////////////////////////////////////////////////////
// bus strobes
////////////////////////////////////////////////////////////

ld_exclusive: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    !(i_bus_wr.addr_ld && i_bus_wr.data_ld))
    else $error("addr_ld and data_ld high in the same cycle");

addr_ld_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_bus_wr.addr_ld |=> !i_bus_wr.addr_ld)
    else $error("addr_ld held longer than one cycle");

data_ld_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_bus_wr.data_ld |=> !i_bus_wr.data_ld)
    else $error("data_ld held longer than one cycle");

// flag resets and lfo update
frst_a_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_timera_frst |=> !i_timera_frst)
    else $error("timer a flag reset held longer than one cycle");

frst_b_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_timerb_frst |=> !i_timerb_frst)
    else $error("timer b flag reset held longer than one cycle");

lfrq_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_lfrq_update |=> !i_lfrq_update)
    else $error("lfo update held longer than one cycle");

////////////////////////////////////////////////////////////
// read port and channel enables
////////////////////////////////////////////////////////////

oe_in_reset: assert property (@(posedge i_EMUCLK)
    !mrst_n |-> !i_d_oe)
    else $error("status output enabled during reset");

grp_we_onehot: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    $onehot0(i_grp_we))
    else $error("more than one channel group enable set");

endmodule

/* test/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk
);

localparam int HALF_PERIOD = 10;    // 20 ns clock

initial begin
    o_clk = 1'b0;
end

always begin
    #HALF_PERIOD;
    o_clk = ~o_clk;
end

endmodule

/* logic/opm_reg_top.sv */
`timescale 1ns/1ps

module opm_reg_top import opm_pkg::*; (
    input  logic              i_EMUCLK,
    input  logic              mrst_n,
    input  logic              i_cs_n,
    input  logic              i_rd_n,
    input  logic              i_wr_n,
    input  logic              i_a0,
    input  logic [7:0]        i_d,
    input  logic              i_timera_flag,
    input  logic              i_timerb_flag,
    output logic [7:0]        o_d,
    output logic              o_d_oe,
    output timer_cfg_t        o_timer,
    output lfo_cfg_t          o_lfo,
    output noise_cfg_t        o_noise,
    output logic              o_timera_frst,
    output logic              o_timerb_frst,
    output logic              o_lfrq_update,
    output logic [SLOT_W-1:0] o_ch_slot,
    output ch_params_t        o_ch_params
);

bus_wr_t            bus_wr;     // synchronized write strobes
logic [NUM_GRP-1:0] grp_we;
ch_data_u           ch_data;
logic [SLOT_W-1:0]  slot;

bus_sync u_bus_sync (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_cs_n   (i_cs_n),
    .i_wr_n   (i_wr_n),
    .i_a0     (i_a0),
    .i_d      (i_d),
    .o_bus_wr (bus_wr)
);

loreg_file u_loreg_file (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_bus_wr      (bus_wr),
    .o_timer       (o_timer),
    .o_lfo         (o_lfo),
    .o_noise       (o_noise),
    .o_timera_frst (o_timera_frst),
    .o_timerb_frst (o_timerb_frst),
    .o_lfrq_update (o_lfrq_update)
);

hireg_latch u_hireg_latch (
    .i_EMUCLK  (i_EMUCLK),
    .mrst_n    (mrst_n),
    .i_bus_wr  (bus_wr),
    .o_grp_we  (grp_we),
    .o_ch_data (ch_data),
    .o_slot    (slot)
);

chan_sr u_chan_sr (
    .i_EMUCLK    (i_EMUCLK),
    .mrst_n      (mrst_n),
    .i_grp_we    (grp_we),
    .i_ch_data   (ch_data),
    .i_slot      (slot),
    .o_ch_params (o_ch_params),
    .o_ch_slot   (o_ch_slot)
);

busy_status u_busy_status (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_bus_wr      (bus_wr),
    .i_cs_n        (i_cs_n),
    .i_rd_n        (i_rd_n),
    .i_a0          (i_a0),
    .i_timera_flag (i_timera_flag),
    .i_timerb_flag (i_timerb_flag),
    .o_d           (o_d),
    .o_d_oe        (o_d_oe)
);

endmodule

/* logic/busy_status.sv */
`timescale 1ns/1ps

module busy_status import opm_pkg::*; (
    input  logic       i_EMUCLK,
    input  logic       mrst_n,
    input  bus_wr_t    i_bus_wr,
    input  logic       i_cs_n,
    input  logic       i_rd_n,
    input  logic       i_a0,
    input  logic       i_timera_flag,
    input  logic       i_timerb_flag,
    output logic [7:0] o_d,
    output logic       o_d_oe
);

logic                  busy;
logic [BUSY_CNT_W-1:0] busy_cnt;
logic                  busy_ovfl;

assign busy_ovfl = busy & (busy_cnt == BUSY_CNT_W'(BUSY_CYCLES - 1));

// write busy timer, restarts on every data byte
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        busy     <= 1'b0;
        busy_cnt <= '0;
    end else if (i_bus_wr.data_ld) begin
        busy     <= 1'b1;
        busy_cnt <= '0;
    end else if (busy) begin
        busy     <= ~busy_ovfl;
        busy_cnt <= busy_cnt + 1'b1;    // wraps back to 0 on overflow
    end
end

////////////////////////////////////////////////////////////
// status read port
////////////////////////////////////////////////////////////

assign o_d    = {busy, 5'b00000, i_timerb_flag, i_timera_flag};
assign o_d_oe = mrst_n & ~i_cs_n & ~i_rd_n & i_a0;  // status only on a0 high

endmodule

/* hireg/chan_sr.sv */
`timescale 1ns/1ps

module chan_sr import opm_pkg::*; (
    input  logic               i_EMUCLK,
    input  logic               mrst_n,
    input  logic [NUM_GRP-1:0] i_grp_we,
    input  ch_data_u           i_ch_data,
    input  logic [SLOT_W-1:0]  i_slot,
    output ch_params_t         o_ch_params,
    output logic [SLOT_W-1:0]  o_ch_slot
);

ch_params_t [NUM_CH-1:0] ring;      // stage NUM_CH-1 is the output
ch_params_t              ring_in;
logic [SLOT_W-1:0]       slot_d;

////////////////////////////////////////////////////////////
// load multiplexer
////////////////////////////////////////////////////////////

always_comb begin
    ring_in = ring[NUM_CH-1];   // recirculate by default
    if (i_grp_we[WE_RL_FL_ALG]) begin
        ring_in.rl  = i_ch_data.rfa.rl;
        ring_in.fl  = i_ch_data.rfa.fl;
        ring_in.alg = i_ch_data.rfa.alg;
    end
    if (i_grp_we[WE_KC]) begin
        ring_in.kc = i_ch_data.kc.kc;
    end
    if (i_grp_we[WE_KF]) begin
        ring_in.kf = i_ch_data.kf.kf;
    end
    if (i_grp_we[WE_PMS_AMS]) begin
        ring_in.pms = i_ch_data.pa.pms;
        ring_in.ams = i_ch_data.pa.ams;
    end
end

////////////////////////////////////////////////////////////
// ring and slot tag
////////////////////////////////////////////////////////////

// ring output lags the counter by NUM_CH+1, one cycle modulo 8
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        ring   <= '0;
        slot_d <= SLOT_W'(NUM_CH - 1);  // counter value before reset release
    end else begin
        ring   <= {ring[NUM_CH-2:0], ring_in};
        slot_d <= i_slot;
    end
end

assign o_ch_params = ring[NUM_CH-1];
assign o_ch_slot   = slot_d;

endmodule

/* hireg/hireg_latch.sv */
`timescale 1ns/1ps

module hireg_latch import opm_pkg::*; (
    input  logic                i_EMUCLK,
    input  logic                mrst_n,
    input  bus_wr_t             i_bus_wr,
    output logic [NUM_GRP-1:0]  o_grp_we,
    output ch_data_u            o_ch_data,
    output logic [SLOT_W-1:0]   o_slot
);

logic [7:0] hi_addr;
logic       hi_addr_vld;
logic       hi_data_vld;
logic       hi_addr_ld;
logic       hi_data_ld;
logic       chan_hit;

// 0x20 to 0x3f share the top three bits
assign hi_addr_ld = i_bus_wr.addr_ld & (i_bus_wr.data[7:5] == GRP_RL_FL_ALG[4:2]);
assign hi_data_ld = i_bus_wr.data_ld & hi_addr_vld;

////////////////////////////////////////////////////////////
// held address and data
////////////////////////////////////////////////////////////

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        hi_addr     <= 8'hFF;
        hi_addr_vld <= 1'b0;
        hi_data_vld <= 1'b0;
    end else begin
        if (hi_addr_ld) begin
            hi_addr <= i_bus_wr.data;
        end
        if (i_bus_wr.addr_ld) begin
            hi_addr_vld <= hi_addr_ld;  // low address drops it
            hi_data_vld <= 1'b0;
        end else if (hi_data_ld) begin
            hi_data_vld <= 1'b1;
        end
    end
end

always_ff @(posedge i_EMUCLK) begin
    if (hi_data_ld) begin
        o_ch_data.raw <= i_bus_wr.data;
    end
end

////////////////////////////////////////////////////////////
// slot counter and group enables
////////////////////////////////////////////////////////////

// rewrites every 8 cycles while data is valid, same value each time
assign chan_hit = hi_data_vld & (o_slot == hi_addr[2:0]);

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        o_slot   <= '0;
        o_grp_we <= '0;
    end else begin
        o_slot                 <= o_slot + 1'b1;    // free running
        o_grp_we[WE_RL_FL_ALG] <= chan_hit & (hi_addr[7:3] == GRP_RL_FL_ALG);
        o_grp_we[WE_KC]        <= chan_hit & (hi_addr[7:3] == GRP_KC);
        o_grp_we[WE_KF]        <= chan_hit & (hi_addr[7:3] == GRP_KF);
        o_grp_we[WE_PMS_AMS]   <= chan_hit & (hi_addr[7:3] == GRP_PMS_AMS);
    end
end

endmodule

/* loreg/loreg_file.sv */
`timescale 1ns/1ps

module loreg_file import opm_pkg::*; (
    input  logic       i_EMUCLK,
    input  logic       mrst_n,
    input  bus_wr_t    i_bus_wr,
    output timer_cfg_t o_timer,
    output lfo_cfg_t   o_lfo,
    output noise_cfg_t o_noise,
    output logic       o_timera_frst,
    output logic       o_timerb_frst,
    output logic       o_lfrq_update
);

logic [7:0] lo_addr;
logic       lo_addr_vld;
logic [7:0] wdata;
logic       data_wr;

assign wdata   = i_bus_wr.data;
assign data_wr = i_bus_wr.data_ld & lo_addr_vld;

// last address byte, any value
always_ff @(posedge i_EMUCLK) begin
    if (i_bus_wr.addr_ld) begin
        lo_addr <= wdata;
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        lo_addr_vld <= 1'b0;
    end else if (i_bus_wr.addr_ld) begin
        lo_addr_vld <= 1'b1;
    end
end

////////////////////////////////////////////////////////////
// flag reset and lfo update strobes
////////////////////////////////////////////////////////////

assign o_timera_frst = data_wr & (lo_addr == ADDR_TIMER_CTRL) & wdata[4];
assign o_timerb_frst = data_wr & (lo_addr == ADDR_TIMER_CTRL) & wdata[5];
assign o_lfrq_update = data_wr & (lo_addr == ADDR_LFRQ);

////////////////////////////////////////////////////////////
// static registers
////////////////////////////////////////////////////////////

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        o_timer <= '0;
        o_lfo   <= '0;
        o_noise <= '0;
    end else if (data_wr) begin
        case (lo_addr)
            ADDR_NOISE: begin
                o_noise.ne   <= wdata[7];
                o_noise.nfrq <= wdata[4:0];
            end
            ADDR_CLKA1: o_timer.clka[9:2] <= wdata;
            ADDR_CLKA2: o_timer.clka[1:0] <= wdata[1:0];
            ADDR_CLKB:  o_timer.clkb      <= wdata;
            ADDR_TIMER_CTRL: begin
                o_timer.run_a    <= wdata[0];
                o_timer.run_b    <= wdata[1];
                o_timer.irq_en_a <= wdata[2];
                o_timer.irq_en_b <= wdata[3];
            end
            ADDR_LFRQ: o_lfo.lfrq <= wdata;
            ADDR_PMD_AMD: begin
                if (wdata[7]) begin
                    o_lfo.pmd <= wdata[6:0];
                end else begin
                    o_lfo.amd <= wdata[6:0];
                end
            end
            ADDR_WAVE: o_lfo.w <= wdata[1:0];  // upper bits not kept
            default: ;
        endcase
    end
end

endmodule

/* logic/bus_sync.sv */
`timescale 1ns/1ps

module bus_sync import opm_pkg::*; (
    input  logic       i_EMUCLK,
    input  logic       mrst_n,
    input  logic       i_cs_n,
    input  logic       i_wr_n,
    input  logic       i_a0,
    input  logic [7:0] i_d,
    output bus_wr_t    o_bus_wr
);

////////////////////////////////////////////////////////////
// pin synchronizers
////////////////////////////////////////////////////////////

logic [1:0]      cs_n_sync;
logic [1:0]      wr_n_sync;
logic [1:0]      a0_sync;
logic [1:0][7:0] d_sync;

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        cs_n_sync <= 2'b11;
        wr_n_sync <= 2'b11;
    end else begin
        cs_n_sync <= {cs_n_sync[0], i_cs_n};
        wr_n_sync <= {wr_n_sync[0], i_wr_n};
    end
end

always_ff @(posedge i_EMUCLK) begin
    a0_sync <= {a0_sync[0], i_a0};
    d_sync  <= {d_sync[0], i_d};
end

////////////////////////////////////////////////////////////
// request flags and strobe chain
////////////////////////////////////////////////////////////

logic       wr_act;
logic       wr_act_d;
logic       wr_start;
logic [1:0] rq_set;     // bit 0 address, bit 1 data
logic [1:0] rq_flag;
logic [1:0] rq_s0;
logic [1:0] rq_s1;
logic [1:0] rq_s2;      // strobe stage
logic [7:0] d_temp;     // follows the bus while the write is low
logic [7:0] d_hold;

assign wr_act   = ~cs_n_sync[1] & ~wr_n_sync[1];
assign wr_start = wr_act & ~wr_act_d;   // one request per write cycle
assign rq_set   = {wr_start & a0_sync[1], wr_start & ~a0_sync[1]};

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        wr_act_d <= 1'b0;
        rq_flag  <= 2'b00;
        rq_s0    <= 2'b00;
        rq_s1    <= 2'b00;
        rq_s2    <= 2'b00;
    end else begin
        wr_act_d <= wr_act;
        rq_flag  <= rq_set | (rq_flag & ~rq_s1);  // held until stage 1 has it
        rq_s0    <= rq_flag & ~rq_s0 & ~rq_s1;    // single cycle into the chain
        rq_s1    <= rq_s0;
        rq_s2    <= rq_s1;
    end
end

always_ff @(posedge i_EMUCLK) begin
    if (wr_act) begin
        d_temp <= d_sync[1];
    end
    // freeze the byte so a quick second write cannot clobber it
    if (|rq_s1) begin
        d_hold <= d_temp;
    end
end

assign o_bus_wr = '{addr_ld: rq_s2[0], data_ld: rq_s2[1], data: d_hold};

endmodule

/* common/opm_pkg.sv */
package opm_pkg;

////////////////////////////////////////////////////////////
// low register map
////////////////////////////////////////////////////////////

localparam logic [7:0] ADDR_NOISE      = 8'h0F; // ne, nfrq
localparam logic [7:0] ADDR_CLKA1      = 8'h10; // timer a bits 9:2
localparam logic [7:0] ADDR_CLKA2      = 8'h11; // timer a bits 1:0
localparam logic [7:0] ADDR_CLKB       = 8'h12;
localparam logic [7:0] ADDR_TIMER_CTRL = 8'h14; // run, irq enable, flag reset
localparam logic [7:0] ADDR_LFRQ       = 8'h18;
localparam logic [7:0] ADDR_PMD_AMD    = 8'h19; // bit 7 picks pmd or amd
localparam logic [7:0] ADDR_WAVE       = 8'h1B;

////////////////////////////////////////////////////////////
// high register groups, upper 5 address bits
////////////////////////////////////////////////////////////

localparam logic [4:0] GRP_RL_FL_ALG = 5'b00100; // 0x20 to 0x27
localparam logic [4:0] GRP_KC        = 5'b00101; // 0x28 to 0x2f
localparam logic [4:0] GRP_KF        = 5'b00110; // 0x30 to 0x37
localparam logic [4:0] GRP_PMS_AMS   = 5'b00111; // 0x38 to 0x3f

// bit positions in the group write enable
localparam int WE_RL_FL_ALG = 0;
localparam int WE_KC        = 1;
localparam int WE_KF        = 2;
localparam int WE_PMS_AMS   = 3;
localparam int NUM_GRP      = 4;

localparam int NUM_CH      = 8;
localparam int SLOT_W      = $clog2(NUM_CH);
localparam int BUSY_CYCLES = 32;
localparam int BUSY_CNT_W  = $clog2(BUSY_CYCLES);

////////////////////////////////////////////////////////////
// bundles
////////////////////////////////////////////////////////////

typedef struct packed {
    logic       addr_ld;    // address byte strobe
    logic       data_ld;    // data byte strobe
    logic [7:0] data;
} bus_wr_t;

typedef struct packed {
    logic [9:0] clka;
    logic [7:0] clkb;
    logic       run_a;
    logic       run_b;
    logic       irq_en_a;
    logic       irq_en_b;
} timer_cfg_t;

typedef struct packed {
    logic [7:0] lfrq;
    logic [6:0] pmd;
    logic [6:0] amd;
    logic [1:0] w;          // lfo waveform
} lfo_cfg_t;

typedef struct packed {
    logic       ne;
    logic [4:0] nfrq;
} noise_cfg_t;

typedef struct packed {
    logic [1:0] rl;
    logic [2:0] fl;
    logic [2:0] alg;
    logic [6:0] kc;
    logic [5:0] kf;
    logic [2:0] pms;
    logic [1:0] ams;
} ch_params_t;

// byte layouts of the four channel groups
typedef struct packed {
    logic [1:0] rl;
    logic [2:0] fl;
    logic [2:0] alg;
} rfa_view_t;

typedef struct packed {
    logic       spare;
    logic [6:0] kc;
} kc_view_t;

typedef struct packed {
    logic [5:0] kf;
    logic [1:0] spare;
} kf_view_t;

typedef struct packed {
    logic       spare_h;
    logic [2:0] pms;
    logic [1:0] spare_m;
    logic [1:0] ams;
} pa_view_t;

typedef union packed {
    logic [7:0] raw;
    rfa_view_t  rfa;
    kc_view_t   kc;
    kf_view_t   kf;
    pa_view_t   pa;
} ch_data_u;

endpackage
